/* rv_core_pkg.sv */
package rv_core_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  ////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////

  // RV32I major opcodes handled by the core
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {RES_ALU, RES_MEM, RES_PC_PLUS_4} result_src_e;
  typedef enum logic [1:0] {SIZE_BYTE, SIZE_HALF, SIZE_WORD} mem_size_e;
  typedef enum logic [1:0] {OPA_REG, OPA_PC, OPA_ZERO} op_a_src_e;
  typedef enum logic [1:0] {FWD_REG, FWD_MEM, FWD_WB} fwd_sel_e;

  // ADDI x0, x0, 0
  localparam word_t NOP_INSN = 32'h0000_0013;

  ////////////////////////////////////////////////////////////
  // Stage records
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic        valid;
    word_t       pc;
    word_t       pc_plus_4;
    reg_addr_t   rs1_addr;
    reg_addr_t   rs2_addr;
    word_t       rs1_data;
    word_t       rs2_data;
    reg_addr_t   rd;
    word_t       imm;
    alu_op_e     alu_op;
    op_a_src_e   a_src;
    logic        b_imm;
    logic        branch;
    logic [2:0]  funct3;
    logic        jump;
    logic        jalr;
    logic        load;
    logic        store;
    mem_size_e   size;
    logic        ld_unsigned;
    result_src_e result_src;
  } id_ex_t;

  typedef struct packed {
    logic        valid;
    word_t       alu_result;
    word_t       store_data;
    reg_addr_t   rd;
    word_t       pc_plus_4;
    logic        load;
    logic        store;
    mem_size_e   size;
    logic        ld_unsigned;
    result_src_e result_src;
  } ex_mem_t;

  typedef struct packed {
    logic  valid;
    word_t target;
  } redirect_t;

  typedef struct packed {
    logic      en;
    reg_addr_t addr;
    word_t     data;
  } rf_write_t;

  typedef struct packed {
    fwd_sel_e rs1;
    fwd_sel_e rs2;
  } fwd_sel_t;

endpackage

/* rv_regfile.sv */
`timescale 1ns/10ps

module rv_regfile (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  rv_core_pkg::reg_addr_t rs1_addr_i,
  input  rv_core_pkg::reg_addr_t rs2_addr_i,
  input  rv_core_pkg::rf_write_t wr_i,
  output rv_core_pkg::word_t     rs1_data_o,
  output rv_core_pkg::word_t     rs2_data_o
);
  import rv_core_pkg::*;

  word_t regs [1:31];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_i.en && wr_i.addr != '0) begin
      regs[wr_i.addr] <= wr_i.data;
    end
  end

  // Write-through so decode sees the value retiring this cycle
  assign rs1_data_o = (rs1_addr_i == '0) ? '0 :
                      (wr_i.en && wr_i.addr == rs1_addr_i) ? wr_i.data : regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 :
                      (wr_i.en && wr_i.addr == rs2_addr_i) ? wr_i.data : regs[rs2_addr_i];

endmodule

/* rv_decode.sv */
`timescale 1ns/10ps

module rv_decode #(
  parameter rv_core_pkg::word_t RESET_PC = '0
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  rv_core_pkg::word_t     imem_rdata_i,
  input  logic                   stall_i,
  input  logic                   flush_i,
  input  rv_core_pkg::redirect_t redirect_i,
  input  rv_core_pkg::rf_write_t wb_i,
  output rv_core_pkg::word_t     imem_addr_o,
  output rv_core_pkg::reg_addr_t rs1_addr_o,
  output rv_core_pkg::reg_addr_t rs2_addr_o,
  output rv_core_pkg::id_ex_t    id_ex_o
);
  import rv_core_pkg::*;

  word_t      pc_q;
  logic       if_id_valid_q;
  word_t      if_id_insn_q;
  word_t      if_id_pc_q;
  opcode_e    opcode;
  logic [2:0] funct3;
  alu_op_e    arith_op;
  logic       use_rs1;
  logic       use_rs2;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;
  word_t      rs1_data;
  word_t      rs2_data;
  id_ex_t     dec;
  id_ex_t     id_ex_q;

  ////////////////////////////////////////////////////////////
  // Fetch
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pc_q <= RESET_PC;
    end else if (redirect_i.valid) begin
      pc_q <= redirect_i.target;
    end else if (!stall_i) begin
      pc_q <= pc_q + 32'd4;
    end
  end

  assign imem_addr_o = pc_q;

  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      if_id_valid_q <= 1'b0;
      if_id_insn_q  <= NOP_INSN;
    end else if (!stall_i) begin
      if_id_valid_q <= 1'b1;
      if_id_insn_q  <= imem_rdata_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      if_id_pc_q <= pc_q;
    end
  end

  ////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////

  assign opcode = opcode_e'(if_id_insn_q[6:0]);
  assign funct3 = if_id_insn_q[14:12];

  assign imm_i = {{20{if_id_insn_q[31]}}, if_id_insn_q[31:20]};
  assign imm_s = {{20{if_id_insn_q[31]}}, if_id_insn_q[31:25], if_id_insn_q[11:7]};
  assign imm_b = {{19{if_id_insn_q[31]}}, if_id_insn_q[31], if_id_insn_q[7],
                  if_id_insn_q[30:25], if_id_insn_q[11:8], 1'b0};
  assign imm_u = {if_id_insn_q[31:12], 12'b0};
  assign imm_j = {{11{if_id_insn_q[31]}}, if_id_insn_q[31], if_id_insn_q[19:12],
                  if_id_insn_q[20], if_id_insn_q[30:21], 1'b0};

  // SUB only exists in the register form
  always_comb begin
    case (funct3)
      3'b000:  arith_op = (opcode == OPC_OP && if_id_insn_q[30]) ? ALU_SUB : ALU_ADD;
      3'b001:  arith_op = ALU_SLL;
      3'b010:  arith_op = ALU_SLT;
      3'b011:  arith_op = ALU_SLTU;
      3'b100:  arith_op = ALU_XOR;
      3'b101:  arith_op = if_id_insn_q[30] ? ALU_SRA : ALU_SRL;
      3'b110:  arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  end

  always_comb begin
    use_rs1         = 1'b0;
    use_rs2         = 1'b0;
    dec             = '0;
    dec.valid       = if_id_valid_q;
    dec.pc          = if_id_pc_q;
    dec.pc_plus_4   = if_id_pc_q + 32'd4;
    dec.funct3      = funct3;
    dec.size        = mem_size_e'(funct3[1:0]);
    dec.ld_unsigned = funct3[2];
    dec.alu_op      = ALU_ADD;
    dec.a_src       = OPA_ZERO;
    dec.result_src  = RES_ALU;
    case (opcode)
      OPC_OP: begin
        use_rs1    = 1'b1;
        use_rs2    = 1'b1;
        dec.rd     = if_id_insn_q[11:7];
        dec.a_src  = OPA_REG;
        dec.alu_op = arith_op;
      end
      OPC_OP_IMM: begin
        use_rs1    = 1'b1;
        dec.rd     = if_id_insn_q[11:7];
        dec.a_src  = OPA_REG;
        dec.b_imm  = 1'b1;
        dec.imm    = imm_i;
        dec.alu_op = arith_op;
      end
      OPC_LUI: begin
        dec.rd     = if_id_insn_q[11:7];
        dec.b_imm  = 1'b1;
        dec.imm    = imm_u;
        dec.alu_op = ALU_PASS_B;
      end
      OPC_AUIPC: begin
        dec.rd    = if_id_insn_q[11:7];
        dec.a_src = OPA_PC;
        dec.b_imm = 1'b1;
        dec.imm   = imm_u;
      end
      OPC_JAL: begin
        dec.rd         = if_id_insn_q[11:7];
        dec.jump       = 1'b1;
        dec.imm        = imm_j;
        dec.result_src = RES_PC_PLUS_4;
      end
      OPC_JALR: begin
        use_rs1        = 1'b1;
        dec.rd         = if_id_insn_q[11:7];
        dec.jump       = 1'b1;
        dec.jalr       = 1'b1;
        dec.imm        = imm_i;
        dec.result_src = RES_PC_PLUS_4;
      end
      OPC_BRANCH: begin
        use_rs1    = 1'b1;
        use_rs2    = 1'b1;
        dec.branch = 1'b1;
        dec.imm    = imm_b;
      end
      OPC_LOAD: begin
        use_rs1        = 1'b1;
        dec.rd         = if_id_insn_q[11:7];
        dec.a_src      = OPA_REG;
        dec.b_imm      = 1'b1;
        dec.imm        = imm_i;
        dec.load       = 1'b1;
        dec.result_src = RES_MEM;
      end
      OPC_STORE: begin
        use_rs1   = 1'b1;
        use_rs2   = 1'b1;
        dec.a_src = OPA_REG;
        dec.b_imm = 1'b1;
        dec.imm   = imm_s;
        dec.store = 1'b1;
      end
      // SYSTEM, FENCE and unknown opcodes fall through as a NOP
      default: ;
    endcase
  end

  assign rs1_addr_o = use_rs1 ? if_id_insn_q[19:15] : '0;
  assign rs2_addr_o = use_rs2 ? if_id_insn_q[24:20] : '0;

  rv_regfile u_regfile (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .rs1_addr_i (rs1_addr_o),
    .rs2_addr_i (rs2_addr_o),
    .wr_i       (wb_i),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  // Bubble on stall or flush
  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i || stall_i) begin
      id_ex_q <= '0;
    end else begin
      id_ex_q          <= dec;
      id_ex_q.rs1_addr <= rs1_addr_o;
      id_ex_q.rs2_addr <= rs2_addr_o;
      id_ex_q.rs1_data <= rs1_data;
      id_ex_q.rs2_data <= rs2_data;
    end
  end

  assign id_ex_o = id_ex_q;

endmodule

/* rv_execute.sv */
`timescale 1ns/10ps

module rv_execute (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  rv_core_pkg::id_ex_t    id_ex_i,
  input  rv_core_pkg::fwd_sel_t  fwd_i,
  input  rv_core_pkg::rf_write_t wb_i,
  output rv_core_pkg::redirect_t redirect_o,
  output rv_core_pkg::ex_mem_t   ex_mem_o
);
  import rv_core_pkg::*;

  word_t   mem_fwd;
  word_t   rs1_val;
  word_t   rs2_val;
  word_t   op_a;
  word_t   op_b;
  word_t   alu_res;
  word_t   target;
  logic    cond;
  ex_mem_t ex_mem_q;

  function automatic word_t fwd_mux(fwd_sel_e sel, word_t reg_val, word_t mem_val,
                                    word_t wb_val);
    case (sel)
      FWD_MEM: return mem_val;
      FWD_WB:  return wb_val;
      default: return reg_val;
    endcase
  endfunction

  // A jump in MEM forwards its link value
  assign mem_fwd = (ex_mem_q.result_src == RES_PC_PLUS_4) ? ex_mem_q.pc_plus_4
                                                          : ex_mem_q.alu_result;

  assign rs1_val = fwd_mux(fwd_i.rs1, id_ex_i.rs1_data, mem_fwd, wb_i.data);
  assign rs2_val = fwd_mux(fwd_i.rs2, id_ex_i.rs2_data, mem_fwd, wb_i.data);

  always_comb begin
    case (id_ex_i.a_src)
      OPA_REG: op_a = rs1_val;
      OPA_PC:  op_a = id_ex_i.pc;
      default: op_a = '0;
    endcase
  end

  assign op_b = id_ex_i.b_imm ? id_ex_i.imm : rs2_val;

  ////////////////////////////////////////////////////////////
  // ALU and branch
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (id_ex_i.alu_op)
      ALU_SUB:  alu_res = op_a - op_b;
      ALU_SLL:  alu_res = op_a << op_b[4:0];
      ALU_SLT:  alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: alu_res = {31'b0, op_a < op_b};
      ALU_XOR:  alu_res = op_a ^ op_b;
      ALU_SRL:  alu_res = op_a >> op_b[4:0];
      ALU_SRA:  alu_res = $signed(op_a) >>> op_b[4:0];
      ALU_OR:   alu_res = op_a | op_b;
      ALU_AND:  alu_res = op_a & op_b;
      ALU_PASS_B: alu_res = op_b;
      default:  alu_res = op_a + op_b;
    endcase
  end

  always_comb begin
    case (id_ex_i.funct3)
      3'b000:  cond = (rs1_val == rs2_val);
      3'b001:  cond = (rs1_val != rs2_val);
      3'b100:  cond = ($signed(rs1_val) < $signed(rs2_val));
      3'b101:  cond = ($signed(rs1_val) >= $signed(rs2_val));
      3'b110:  cond = (rs1_val < rs2_val);
      3'b111:  cond = (rs1_val >= rs2_val);
      default: cond = 1'b0;
    endcase
  end

  assign target = (id_ex_i.jalr ? rs1_val : id_ex_i.pc) + id_ex_i.imm;

  assign redirect_o = '{
    valid:  id_ex_i.valid && (id_ex_i.jump || (id_ex_i.branch && cond)),
    target: {target[31:1], target[0] & ~id_ex_i.jalr}
  };

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ex_mem_q <= '0;
    end else begin
      ex_mem_q.valid       <= id_ex_i.valid;
      ex_mem_q.alu_result  <= alu_res;
      ex_mem_q.store_data  <= rs2_val;
      ex_mem_q.rd          <= id_ex_i.rd;
      ex_mem_q.pc_plus_4   <= id_ex_i.pc_plus_4;
      ex_mem_q.load        <= id_ex_i.load;
      ex_mem_q.store       <= id_ex_i.store;
      ex_mem_q.size        <= id_ex_i.size;
      ex_mem_q.ld_unsigned <= id_ex_i.ld_unsigned;
      ex_mem_q.result_src  <= id_ex_i.result_src;
    end
  end

  assign ex_mem_o = ex_mem_q;

endmodule

/* rv_result.sv */
`timescale 1ns/10ps

module rv_result (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  rv_core_pkg::ex_mem_t   ex_mem_i,
  input  rv_core_pkg::word_t     dmem_rdata_i,
  output rv_core_pkg::word_t     dmem_addr_o,
  output rv_core_pkg::word_t     dmem_wdata_o,
  output logic [3:0]             dmem_wmask_o,
  output rv_core_pkg::rf_write_t wb_o
);
  import rv_core_pkg::*;

  ex_mem_t mem_wb_q;
  word_t   lane;
  word_t   load_val;
  word_t   result;

  assign dmem_addr_o = ex_mem_i.alu_result;

  // Store data replicated over all lanes, mask picks the lanes
  always_comb begin
    case (ex_mem_i.size)
      SIZE_BYTE: begin
        dmem_wdata_o = {4{ex_mem_i.store_data[7:0]}};
        dmem_wmask_o = 4'b0001 << ex_mem_i.alu_result[1:0];
      end
      SIZE_HALF: begin
        dmem_wdata_o = {2{ex_mem_i.store_data[15:0]}};
        dmem_wmask_o = ex_mem_i.alu_result[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        dmem_wdata_o = ex_mem_i.store_data;
        dmem_wmask_o = 4'b1111;
      end
    endcase
    if (!ex_mem_i.store) begin
      dmem_wmask_o = 4'b0000;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mem_wb_q <= '0;
    end else begin
      mem_wb_q <= ex_mem_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Writeback
  ////////////////////////////////////////////////////////////

  assign lane = dmem_rdata_i >> {mem_wb_q.alu_result[1:0], 3'b000};

  always_comb begin
    case (mem_wb_q.size)
      SIZE_BYTE: load_val = {{24{~mem_wb_q.ld_unsigned & lane[7]}}, lane[7:0]};
      SIZE_HALF: load_val = {{16{~mem_wb_q.ld_unsigned & lane[15]}}, lane[15:0]};
      default:   load_val = lane;
    endcase
  end

  always_comb begin
    case (mem_wb_q.result_src)
      RES_MEM:       result = load_val;
      RES_PC_PLUS_4: result = mem_wb_q.pc_plus_4;
      default:       result = mem_wb_q.alu_result;
    endcase
  end

  assign wb_o = '{
    en:   mem_wb_q.valid && (mem_wb_q.rd != '0),
    addr: mem_wb_q.rd,
    data: result
  };

endmodule

/* rv_hazard.sv */
`timescale 1ns/10ps

module rv_hazard (
  input  rv_core_pkg::reg_addr_t id_rs1_i,
  input  rv_core_pkg::reg_addr_t id_rs2_i,
  input  rv_core_pkg::id_ex_t    id_ex_i,
  input  rv_core_pkg::ex_mem_t   ex_mem_i,
  input  rv_core_pkg::rf_write_t wb_i,
  input  rv_core_pkg::redirect_t redirect_i,
  output logic                   stall_o,
  output logic                   flush_o,
  output rv_core_pkg::fwd_sel_t  fwd_o
);
  import rv_core_pkg::*;

  logic mem_ok;
  logic load_use;

  // MEM wins over WB, x0 never forwards
  function automatic fwd_sel_e pick(reg_addr_t rs, logic mem_en, reg_addr_t mem_rd,
                                    logic wb_en, reg_addr_t wb_rd);
    if (rs == '0) return FWD_REG;
    if (mem_en && mem_rd == rs) return FWD_MEM;
    if (wb_en && wb_rd == rs) return FWD_WB;
    return FWD_REG;
  endfunction

  // Load data is not ready in MEM
  assign mem_ok = ex_mem_i.valid && !ex_mem_i.load;

  assign fwd_o = '{
    rs1: pick(id_ex_i.rs1_addr, mem_ok, ex_mem_i.rd, wb_i.en, wb_i.addr),
    rs2: pick(id_ex_i.rs2_addr, mem_ok, ex_mem_i.rd, wb_i.en, wb_i.addr)
  };

  assign load_use = id_ex_i.valid && id_ex_i.load && (id_ex_i.rd != '0) &&
                    (id_ex_i.rd == id_rs1_i || id_ex_i.rd == id_rs2_i);

  assign flush_o = redirect_i.valid;
  assign stall_o = load_use && !flush_o;

endmodule

/* rv_core.sv */
`timescale 1ns/10ps

module rv_core #(
  parameter rv_core_pkg::word_t RESET_PC = '0
) (
  input  logic               clk_i,
  input  logic               rst_i,
  input  rv_core_pkg::word_t imem_rdata_i,
  input  rv_core_pkg::word_t dmem_rdata_i,
  output rv_core_pkg::word_t imem_addr_o,
  output rv_core_pkg::word_t dmem_addr_o,
  output rv_core_pkg::word_t dmem_wdata_o,
  output logic [3:0]         dmem_wmask_o
);
  import rv_core_pkg::*;

  reg_addr_t id_rs1;
  reg_addr_t id_rs2;
  id_ex_t    id_ex;
  ex_mem_t   ex_mem;
  redirect_t redirect;
  rf_write_t wb;
  fwd_sel_t  fwd;
  logic      stall;
  logic      flush;

  rv_decode #(
    .RESET_PC (RESET_PC)
  ) u_decode (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .imem_rdata_i (imem_rdata_i),
    .stall_i      (stall),
    .flush_i      (flush),
    .redirect_i   (redirect),
    .wb_i         (wb),
    .imem_addr_o  (imem_addr_o),
    .rs1_addr_o   (id_rs1),
    .rs2_addr_o   (id_rs2),
    .id_ex_o      (id_ex)
  );

  rv_execute u_execute (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .id_ex_i    (id_ex),
    .fwd_i      (fwd),
    .wb_i       (wb),
    .redirect_o (redirect),
    .ex_mem_o   (ex_mem)
  );

  rv_result u_result (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .ex_mem_i     (ex_mem),
    .dmem_rdata_i (dmem_rdata_i),
    .dmem_addr_o  (dmem_addr_o),
    .dmem_wdata_o (dmem_wdata_o),
    .dmem_wmask_o (dmem_wmask_o),
    .wb_o         (wb)
  );

  rv_hazard u_hazard (
    .id_rs1_i   (id_rs1),
    .id_rs2_i   (id_rs2),
    .id_ex_i    (id_ex),
    .ex_mem_i   (ex_mem),
    .wb_i       (wb),
    .redirect_i (redirect),
    .stall_o    (stall),
    .flush_o    (flush),
    .fwd_o      (fwd)
  );

endmodule

/* rv_core_chk.sv */
`timescale 1ns/10ps

module rv_core_chk (
  input logic               clk_i,
  input logic               rst_i,
  input rv_core_pkg::word_t imem_addr_o,
  input logic [3:0]         dmem_wmask_o
);
  import rv_core_pkg::*;

  // Only byte, half and word lane patterns exist
  mask_legal: assert property (@(posedge clk_i) disable iff (rst_i)
    dmem_wmask_o inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000,
                         4'b0011, 4'b1100, 4'b1111})
    else $error("Write mask %b is not a legal lane pattern", dmem_wmask_o);

  fetch_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
    imem_addr_o[1:0] == 2'b00)
    else $error("Fetch address %h is not word aligned", imem_addr_o);

  // First reset edge clears the pipeline registers
  mask_quiet_in_reset: assert property (@(posedge clk_i)
    rst_i && $past(rst_i) |-> dmem_wmask_o == 4'b0000)
    else $error("Write mask %b seen during reset", dmem_wmask_o);

endmodule

bind rv_core rv_core_chk u_chk (.*);

/* tb_rv_core.sv */
`timescale 1ns/10ps

module tb_rv_core;
  import rv_core_pkg::*;

  localparam int    IMEM_WORDS = 512;
  localparam int    DMEM_BYTES = 4096;
  localparam word_t JAL_SELF   = 32'h0000_006f;
  localparam word_t BOOT_PC    = 32'h0;

  logic       clk_i;
  logic       rst_i;
  word_t      imem_rdata_i;
  word_t      dmem_rdata_i;
  word_t      imem_addr_o;
  word_t      dmem_addr_o;
  word_t      dmem_wdata_o;
  logic [3:0] dmem_wmask_o;

  word_t      imem [IMEM_WORDS];
  logic [7:0] dmem [DMEM_BYTES];
  logic [7:0] ref_mem [DMEM_BYTES];
  word_t      exp_addr [$];
  word_t      exp_data [$];
  word_t      exp_mask [$];

  int         seed;
  int         prog_len;
  int         out_off;
  int         error_count;
  int         store_count;
  int         pass_count;
  int         fail_count;
  longint     cycle_count = 0;
  longint     cycle_limit = 1000;
  word_t      rd_addr_q;
  word_t      s_addr;
  word_t      s_wdata;
  logic [3:0] s_mask;

  rv_core #(
    .RESET_PC (BOOT_PC)
  ) uut (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .imem_rdata_i (imem_rdata_i),
    .dmem_rdata_i (dmem_rdata_i),
    .imem_addr_o  (imem_addr_o),
    .dmem_addr_o  (dmem_addr_o),
    .dmem_wdata_o (dmem_wdata_o),
    .dmem_wmask_o (dmem_wmask_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  assign imem_rdata_i = imem[imem_addr_o[10:2]];

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic int rnd_below(int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic word_t read_word(word_t a);
    return {dmem[{a[11:2], 2'd3}], dmem[{a[11:2], 2'd2}],
            dmem[{a[11:2], 2'd1}], dmem[{a[11:2], 2'd0}]};
  endfunction

  function automatic word_t enc_r(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3,
                                  int rd, logic [6:0] op);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], op};
  endfunction

  function automatic word_t enc_i(int imm, int rs1, logic [2:0] f3, int rd, logic [6:0] op);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
  endfunction

  function automatic word_t enc_s(int imm, int rs2, int rs1, logic [2:0] f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic word_t enc_b(int imm, int rs2, int rs1, logic [2:0] f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic word_t enc_u(int imm, int rd, logic [6:0] op);
    return {imm[19:0], rd[4:0], op};
  endfunction

  function automatic word_t enc_j(int imm, int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
  endfunction

  task automatic emit(word_t insn);
    imem[prog_len] = insn;
    prog_len++;
  endtask

  // Results go to a word area above the load/store scratch area
  task automatic store_reg(int rs);
    emit(enc_s(out_off, rs, 31, 3'b010));
    out_off = 1024 + ((out_off - 1024 + 4) % 1024);
  endtask

  task automatic emit_alu(int rd, int rs1, int rs2);
    int f3;
    int imm;
    logic alt;
    f3 = rnd_below(8);
    alt = (f3 == 0 || f3 == 5) && rnd_below(2) == 1;
    if (rnd_below(2) == 1) begin
      emit(enc_r(alt ? 7'h20 : 7'h00, rs2, rs1, f3[2:0], rd, OPC_OP));
    end else begin
      if (f3 == 1 || f3 == 5) begin
        imm = rnd_below(32) | ((f3 == 5 && alt) ? 32'h400 : 0);
      end else begin
        imm = $random(seed);
      end
      emit(enc_i(imm, rs1, f3[2:0], rd, OPC_OP_IMM));
    end
  endtask

  task automatic check_value(string what, word_t got, word_t exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      error_count++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // ISA reference model
  ////////////////////////////////////////////////////////////

  function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic word_t load_ref(word_t addr, logic [2:0] f3);
    word_t w;
    word_t lane;
    w = {ref_mem[{addr[11:2], 2'd3}], ref_mem[{addr[11:2], 2'd2}],
         ref_mem[{addr[11:2], 2'd1}], ref_mem[{addr[11:2], 2'd0}]};
    lane = w >> (8 * addr[1:0]);
    case (f3)
      3'd0:    return {{24{lane[7]}}, lane[7:0]};
      3'd1:    return {{16{lane[15]}}, lane[15:0]};
      3'd4:    return {24'b0, lane[7:0]};
      3'd5:    return {16'b0, lane[15:0]};
      default: return w;
    endcase
  endfunction

  function automatic void store_ref(word_t addr, logic [2:0] f3, word_t v);
    word_t      data;
    logic [3:0] mask;
    case (f3)
      3'd0: begin
        data = {4{v[7:0]}};
        mask = 4'b0001 << addr[1:0];
      end
      3'd1: begin
        data = {2{v[15:0]}};
        mask = addr[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        data = v;
        mask = 4'b1111;
      end
    endcase
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) ref_mem[{addr[11:2], b[1:0]}] = data[8*b +: 8];
    end
    exp_addr.push_back(addr);
    exp_data.push_back(data);
    exp_mask.push_back({28'b0, mask});
  endfunction

  function automatic void run_model();
    word_t      r [32];
    word_t      pc;
    word_t      insn;
    word_t      next;
    word_t      res;
    word_t      imm_i;
    word_t      a;
    word_t      b;
    logic [2:0] f3;
    logic       wr;
    logic       taken;
    for (int i = 0; i < 32; i++) r[i] = '0;
    pc = BOOT_PC;
    for (int steps = 0; steps < 4096; steps++) begin
      insn = imem[pc[10:2]];
      if (insn == JAL_SELF) break;
      f3 = insn[14:12];
      a = r[insn[19:15]];
      b = r[insn[24:20]];
      imm_i = {{20{insn[31]}}, insn[31:20]};
      res = '0;
      wr = 1'b1;
      next = pc + 4;
      case (insn[6:0])
        7'b0110011: res = alu_ref(f3, insn[30], a, b);
        7'b0010011: res = alu_ref(f3, insn[30] && f3 == 3'd5, a, imm_i);
        7'b0110111: res = {insn[31:12], 12'b0};
        7'b0010111: res = pc + {insn[31:12], 12'b0};
        7'b1101111: begin
          res = pc + 4;
          next = pc + {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
        end
        7'b1100111: begin
          res = pc + 4;
          next = (a + imm_i) & ~32'd1;
        end
        7'b1100011: begin
          wr = 1'b0;
          case (f3)
            3'd0:    taken = a == b;
            3'd1:    taken = a != b;
            3'd4:    taken = $signed(a) < $signed(b);
            3'd5:    taken = $signed(a) >= $signed(b);
            3'd6:    taken = a < b;
            default: taken = a >= b;
          endcase
          if (taken) begin
            next = pc + {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
          end
        end
        7'b0000011: res = load_ref(a + imm_i, f3);
        7'b0100011: begin
          wr = 1'b0;
          store_ref(a + {{20{insn[31]}}, insn[31:25], insn[11:7]}, f3, b);
        end
        default: wr = 1'b0;
      endcase
      if (wr && insn[11:7] != 5'd0) r[insn[11:7]] = res;
      pc = next;
    end
  endfunction

  ////////////////////////////////////////////////////////////
  // Program generation
  ////////////////////////////////////////////////////////////

  task automatic gen_program(int t);
    int       a;
    int       b;
    int       prev;
    int       sz;
    int       off;
    int       lk;
    int       loff;
    int       f3;
    int       ld_kinds [5];
    int       br_kinds [6];
    ld_kinds = '{0, 1, 2, 4, 5};
    br_kinds = '{0, 1, 4, 5, 6, 7};
    emit(enc_i(1024, 0, 3'd0, 31, OPC_OP_IMM));
    for (int r = 1; r <= 8; r++) begin
      emit(enc_u($random(seed), r, OPC_LUI));
      emit(enc_i($random(seed), r, 3'd0, r, OPC_OP_IMM));
    end
    prev = 1;
    case (t)
      1: for (int k = 0; k < 12; k++) begin
        a = 1 + rnd_below(8);
        b = 1 + rnd_below(8);
        emit_alu(a, prev, 1 + rnd_below(8));
        emit_alu(b, a, prev);
        store_reg(a);
        store_reg(b);
        prev = b;
      end
      2: for (int k = 0; k < 10; k++) begin
        a = 1 + rnd_below(8);
        b = 1 + rnd_below(8);
        emit(enc_u($random(seed), a, OPC_LUI));
        store_reg(a);
        emit(enc_u($random(seed), b, OPC_AUIPC));
        store_reg(b);
        f3 = rnd_below(2) ? 5 : 1;
        off = (f3 == 5 && rnd_below(2) == 1) ? 32'h400 : 0;
        emit(enc_i(rnd_below(32) | off, a, f3[2:0], 9, OPC_OP_IMM));
        store_reg(9);
        emit(enc_r(off[10] ? 7'h20 : 7'h00, b, a, f3[2:0], 10, OPC_OP));
        store_reg(10);
      end
      3: for (int k = 0; k < 12; k++) begin
        emit(enc_u($random(seed), 5, OPC_LUI));
        emit(enc_i($random(seed), 5, 3'd0, 5, OPC_OP_IMM));
        sz = rnd_below(3);
        off = rnd_below(1024) & ~((1 << sz) - 1);
        emit(enc_s(off, 5, 31, sz[2:0]));
        lk = ld_kinds[rnd_below(5)];
        loff = rnd_below(2) ? off : rnd_below(1024);
        loff = loff & ~((1 << (lk & 3)) - 1);
        emit(enc_i(loff, 31, lk[2:0], 6, OPC_LOAD));
        // Dependent use right behind the load
        emit(enc_i(1, 6, 3'd0, 7, OPC_OP_IMM));
        store_reg(6);
        store_reg(7);
      end
      4: for (int k = 0; k < 8; k++) begin
        emit(enc_i(rnd_below(5) - 2, 0, 3'd0, 1, OPC_OP_IMM));
        emit(enc_i(rnd_below(5) - 2, 0, 3'd0, 2, OPC_OP_IMM));
        f3 = br_kinds[rnd_below(6)];
        emit(enc_b(12, 2, 1, f3[2:0]));
        store_reg(1);
        store_reg(2);
        emit(enc_j(12, 5));
        store_reg(1);
        store_reg(2);
        store_reg(5);
        emit(enc_u(0, 6, OPC_AUIPC));
        emit(enc_i(17, 6, 3'd0, 7, OPC_JALR));
        store_reg(1);
        store_reg(2);
        store_reg(7);
      end
      default: for (int k = 0; k < 8; k++) begin
        case (rnd_below(5))
          0: emit(enc_i($random(seed), 0, 3'd0, 0, OPC_OP_IMM));
          1: emit(enc_u($random(seed), 0, OPC_LUI));
          2: emit(enc_r(7'h00, 2, 1, 3'd0, 0, OPC_OP));
          3: emit(enc_i(4 * rnd_below(256), 31, 3'd2, 0, OPC_LOAD));
          default: emit(enc_j(4, 0));
        endcase
        store_reg(0);
        emit(enc_i(0, 0, 3'd0, 3, OPC_OP_IMM));
        store_reg(3);
      end
    endcase
    emit(JAL_SELF);
  endtask

  ////////////////////////////////////////////////////////////
  // Memory model and store comparison
  ////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    s_addr = dmem_addr_o;
    s_wdata = dmem_wdata_o;
    s_mask = dmem_wmask_o;
    dmem_rdata_i <= read_word(rd_addr_q);
  end

  always @(posedge clk_i) begin
    rd_addr_q <= s_addr;
    if (!rst_i && s_mask != 4'b0000) begin
      if (exp_addr.size() == 0) begin
        $display("Unexpected store to address %h at %0t ns", s_addr, $time);
        error_count++;
      end else begin
        check_value("store address", s_addr, exp_addr.pop_front());
        check_value("store data", s_wdata, exp_data.pop_front());
        check_value("store mask", {28'b0, s_mask}, exp_mask.pop_front());
        store_count++;
      end
      for (int b = 0; b < 4; b++) begin
        if (s_mask[b]) dmem[{s_addr[11:2], b[1:0]}] = s_wdata[8*b +: 8];
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("Timeout: the core did not finish its stores in time");
      $display("** FAIL **");
      $finish;
    end
  end

  task automatic run_test(int t, string name);
    int expected;
    int errs_before;
    @(negedge clk_i);
    rst_i = 1'b1;
    prog_len = 0;
    out_off = 1024;
    for (int i = 0; i < IMEM_WORDS; i++) imem[i] = NOP_INSN;
    gen_program(t);
    for (int i = 0; i < DMEM_BYTES; i++) begin
      dmem[i] = i[7:0] ^ {i[11:8], i[11:8]} ^ 8'h5a;
      ref_mem[i] = dmem[i];
    end
    exp_addr.delete();
    exp_data.delete();
    exp_mask.delete();
    run_model();
    expected = exp_addr.size();
    store_count = 0;
    errs_before = error_count;
    cycle_limit = cycle_count + prog_len * 8 + 64;
    repeat (4) @(negedge clk_i);
    rst_i = 1'b0;
    check_value("fetch address after reset", imem_addr_o, BOOT_PC);
    while (store_count < expected) @(negedge clk_i);
    // Time for any stray store to show up
    repeat (20) @(negedge clk_i);
    if (error_count == errs_before) begin
      pass_count++;
      $display("Test %0d %s: %0d stores matched", t, name, expected);
    end else begin
      fail_count++;
      $display("Test %0d %s: %0d errors", t, name, error_count - errs_before);
    end
  endtask

  initial begin
    seed = 32'ha07d_6b22;
    rst_i = 1'b1;
    dmem_rdata_i = '0;
    rd_addr_q = '0;
    error_count = 0;
    pass_count = 0;
    fail_count = 0;
    run_test(1, "alu chains");
    run_test(2, "lui auipc shifts");
    run_test(3, "loads and stores");
    run_test(4, "branches and jumps");
    run_test(5, "x0 writes");
    $display("Tests passed %0d, failed %0d, errors %0d", pass_count, fail_count, error_count);
    if (fail_count == 0 && error_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* rv_core.f */
rv_core_pkg.sv
rv_regfile.sv
rv_decode.sv
rv_execute.sv
rv_result.sv
rv_hazard.sv
rv_core.sv
rv_core_chk.sv
tb_rv_core.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - rv_core_pkg.sv
  - rv_regfile.sv
  - rv_decode.sv
  - rv_execute.sv
  - rv_result.sv
  - rv_hazard.sv
  - rv_core.sv
  - target: test
    files:
      - rv_core_chk.sv
      - tb_rv_core.sv
